// File: rtl/frame_pkg.sv
package frame_pkg;

    // frame buffer holds 4096 bytes
    localparam int addr_w = 12;

    // packet type codes, these also form the high nibble of each header byte
    typedef enum logic [3:0] {
        bag_dlink = 4'b1000,
        bag_dtype = 4'b1001,
        bag_dtemp = 4'b1010,
        bag_data0 = 4'b1101
    } btype_t;

    // first buffer address of each packet type
    localparam logic [addr_w-1:0] base_dlink = 12'hfcc;
    localparam logic [addr_w-1:0] base_dtype = 12'hfc0;
    localparam logic [addr_w-1:0] base_dtemp = 12'hfc8;
    localparam logic [addr_w-1:0] base_data0 = 12'h000;

    // packets per frame
    localparam int pkt_count = 4;

    // cycles from conversion request to conversion done
    localparam int conv_delay = 4;

    // command handed from the sequencer to the builder
    typedef struct packed {
        btype_t            btype;
        logic [3:0]        seq;
        logic [addr_w-1:0] base;
    } pkt_cmd_t;

    // one byte write into the frame buffer
    typedef struct packed {
        logic              en;
        logic [addr_w-1:0] addr;
        logic [7:0]        data;
    } buf_wr_t;

    // number of payload bytes carried by each packet type
    function automatic logic [3:0] payload_len(input btype_t btype);
        logic [3:0] len;
        case (btype)
            bag_dlink: len = 4'd4;
            bag_dtype: len = 4'd4;
            bag_dtemp: len = 4'd2;
            bag_data0: len = 4'd8;
            default:   len = 4'd0;
        endcase
        return len;
    endfunction

endpackage

// File: rtl/sample_source.sv
`timescale 1ns/1ps

module sample_source (
    input  logic        clk,
    input  logic        rst,
    input  logic        conv_start,
    output logic        conv_done,
    output logic [63:0] sample_word,
    output logic [15:0] temp
);

    import frame_pkg::*;

    logic [2:0]  delay_cnt;
    logic        pending;
    logic [15:0] conv_idx;
    logic        fire;

    // last cycle of the conversion window
    assign fire = pending && (delay_cnt == 3'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            delay_cnt <= '0;
            pending   <= 1'b0;
            conv_done <= 1'b0;
            conv_idx  <= '0;
        end else begin
            conv_done <= fire;
            if (conv_start) begin
                pending   <= 1'b1;
                delay_cnt <= 3'(conv_delay - 1);
            end else if (fire) begin
                pending  <= 1'b0;
                conv_idx <= conv_idx + 16'd1;
            end else if (pending) begin
                delay_cnt <= delay_cnt - 3'd1;
            end
        end
    end

    // channel i of conversion k reads 8k + i, temperature ramps from 0x190
    always_ff @(posedge clk) begin
        if (fire) begin
            for (int i = 0; i < 8; i++) begin
                sample_word[8*i +: 8] <= {conv_idx[4:0], 3'(i)};
            end
            temp <= 16'h0190 + conv_idx;
        end
    end

    // the sequencer has to wait for conv_done before it asks again
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        conv_start |-> !pending);

endmodule

// File: rtl/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    output logic                conv_start,
    input  logic                conv_done,
    output logic                pkt_start,
    output frame_pkg::pkt_cmd_t pkt_cmd,
    input  logic                pkt_done,
    output logic                busy,
    output logic                frame_done
);

    import frame_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_wait,
        s_conv,
        s_issue,
        s_work,
        s_count,
        s_done
    } state_t;

    state_t                         state;
    state_t                         next_state;
    logic [$clog2(pkt_count)-1:0]   pkt_idx;
    logic [3:0]                     frame_cnt;
    btype_t                         btype;
    logic [addr_w-1:0]              base;

    always_comb begin
        next_state = state;
        case (state)
            s_idle:  next_state = s_wait;
            s_wait:  next_state = start ? s_conv : s_wait;
            s_conv:  next_state = conv_done ? s_issue : s_conv;
            s_issue: next_state = s_work;
            s_work:  next_state = pkt_done ? s_count : s_work;
            s_count: begin
                if (pkt_idx == ($clog2(pkt_count))'(pkt_count - 1)) begin
                    next_state = s_done;
                end else begin
                    next_state = s_issue;
                end
            end
            s_done:  next_state = s_wait;
            default: next_state = s_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= s_idle;
            conv_start <= 1'b0;
            pkt_idx    <= '0;
            frame_cnt  <= '0;
        end else begin
            state      <= next_state;
            // a start outside the wait state is dropped
            conv_start <= (state == s_wait) && start;
            if (state == s_wait) begin
                pkt_idx <= '0;
            end else if (state == s_count) begin
                pkt_idx <= pkt_idx + 1'b1;
            end
            if (state == s_done) begin
                frame_cnt <= frame_cnt + 4'd1;
            end
        end
    end

    // decode stage, packet index to type and base address
    always_comb begin
        case (pkt_idx)
            2'd0: begin
                btype = bag_dlink;
                base  = base_dlink;
            end
            2'd1: begin
                btype = bag_dtype;
                base  = base_dtype;
            end
            2'd2: begin
                btype = bag_dtemp;
                base  = base_dtemp;
            end
            default: begin
                btype = bag_data0;
                base  = base_data0;
            end
        endcase
    end

    assign pkt_cmd    = '{btype: btype, seq: frame_cnt, base: base};
    assign pkt_start  = (state == s_issue);
    assign frame_done = (state == s_done);
    assign busy       = (state != s_idle) && (state != s_wait);

    // the builder only finishes a packet that was issued to it
    a_done_in_work: assert property (@(posedge clk) disable iff (rst)
        pkt_done |-> state == s_work);

endmodule

// File: rtl/packet_builder.sv
`timescale 1ns/1ps

module packet_builder (
    input  logic                clk,
    input  logic                rst,
    input  logic                pkt_start,
    input  frame_pkg::pkt_cmd_t pkt_cmd,
    input  logic [31:0]         data_reg,
    input  logic [31:0]         data_stat,
    input  logic [15:0]         temp,
    input  logic [63:0]         sample_word,
    output frame_pkg::buf_wr_t  buf_wr,
    output logic                pkt_done
);

    import frame_pkg::*;

    pkt_cmd_t    cmd_q;
    logic [63:0] payload_sel;
    logic [63:0] payload_q;
    logic        active;
    logic [3:0]  byte_idx;
    logic [3:0]  last_idx;
    logic [7:0]  sum;
    logic [7:0]  wr_byte;

    // payload is left aligned so the next byte to send is always the top one
    always_comb begin
        case (pkt_cmd.btype)
            bag_dlink: payload_sel = {data_reg, 32'h0};
            bag_dtype: payload_sel = {data_stat, 32'h0};
            bag_dtemp: payload_sel = {temp, 48'h0};
            default:   payload_sel = sample_word;
        endcase
    end

    // the checksum sits one past the last payload byte
    assign last_idx = payload_len(cmd_q.btype) + 4'd1;

    always_comb begin
        if (byte_idx == 4'd0) begin
            wr_byte = {cmd_q.btype, cmd_q.seq};
        end else if (byte_idx == last_idx) begin
            wr_byte = sum;
        end else begin
            wr_byte = payload_q[63:56];
        end
    end

    // address wraps modulo the buffer size
    assign buf_wr.en   = active;
    assign buf_wr.addr = cmd_q.base + addr_w'(byte_idx);
    assign buf_wr.data = wr_byte;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active   <= 1'b0;
            byte_idx <= '0;
            pkt_done <= 1'b0;
        end else begin
            pkt_done <= active && (byte_idx == last_idx);
            if (pkt_start) begin
                active   <= 1'b1;
                byte_idx <= '0;
            end else if (active) begin
                if (byte_idx == last_idx) begin
                    active <= 1'b0;
                end
                byte_idx <= byte_idx + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_start) begin
            cmd_q     <= pkt_cmd;
            payload_q <= payload_sel;
            sum       <= '0;
        end else if (active) begin
            sum <= sum + wr_byte;
            // header cycle leaves the payload in place
            if (byte_idx != 4'd0) begin
                payload_q <= payload_q << 8;
            end
        end
    end

    // one packet at a time, the sequencer waits for pkt_done
    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        pkt_start |-> !active);

endmodule

// File: rtl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
    input  logic                         clk,
    input  frame_pkg::buf_wr_t           buf_wr,
    input  logic [frame_pkg::addr_w-1:0] rd_addr,
    output logic [7:0]                   rd_data
);

    import frame_pkg::*;

    logic [7:0] mem [2**addr_w];

    // builder side
    always_ff @(posedge clk) begin
        if (buf_wr.en) begin
            mem[buf_wr.addr] <= buf_wr.data;
        end
    end

    // readback port, one cycle behind the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rtl/frame_top.sv
`timescale 1ns/1ps

module frame_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic [31:0]                  data_reg,
    input  logic [31:0]                  data_stat,
    input  logic [frame_pkg::addr_w-1:0] rd_addr,
    output logic                         busy,
    output logic                         frame_done,
    output logic [7:0]                   rd_data
);

    import frame_pkg::*;

    logic        conv_start;
    logic        conv_done;
    logic [63:0] sample_word;
    logic [15:0] temp;
    logic        pkt_start;
    logic        pkt_done;
    pkt_cmd_t    pkt_cmd;
    buf_wr_t     buf_wr;

    sample_source sample_source_i (
        .clk         (clk),
        .rst         (rst),
        .conv_start  (conv_start),
        .conv_done   (conv_done),
        .sample_word (sample_word),
        .temp        (temp)
    );

    frame_sequencer frame_sequencer_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .conv_start (conv_start),
        .conv_done  (conv_done),
        .pkt_start  (pkt_start),
        .pkt_cmd    (pkt_cmd),
        .pkt_done   (pkt_done),
        .busy       (busy),
        .frame_done (frame_done)
    );

    packet_builder packet_builder_i (
        .clk         (clk),
        .rst         (rst),
        .pkt_start   (pkt_start),
        .pkt_cmd     (pkt_cmd),
        .data_reg    (data_reg),
        .data_stat   (data_stat),
        .temp        (temp),
        .sample_word (sample_word),
        .buf_wr      (buf_wr),
        .pkt_done    (pkt_done)
    );

    frame_buffer frame_buffer_i (
        .clk     (clk),
        .buf_wr  (buf_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: tb/frame_checker.sv
`timescale 1ns/1ps

module frame_checker #(
    parameter int n_frames = 6,
    parameter int rec_len  = 34
) (
    input  logic       clk,
    input  logic       rd_en,
    input  logic [7:0] rd_data,
    output int         errors,
    output int         frames_checked,
    output int         bytes_checked
);

    // each record opens with eight stimulus bytes and the rest is readback
    localparam int stim_len = 8;
    localparam int exp_len  = rec_len - stim_len;

    logic [7:0] golden [n_frames*rec_len];
    logic       rd_en_q;
    logic [7:0] expected;
    int         byte_idx;
    int         frame_errors;

    initial begin
        $readmemh("tb/frame_golden.txt", golden);
        rd_en_q        = 1'b0;
        byte_idx       = 0;
        frame_errors   = 0;
        errors         = 0;
        frames_checked = 0;
        bytes_checked  = 0;
    end

    // rd_data belongs to the address that was driven one cycle earlier
    always @(posedge clk) begin
        if (rd_en_q) begin
            expected = golden[frames_checked*rec_len + stim_len + byte_idx];
            bytes_checked++;
            if (rd_data !== expected) begin
                $display("Mismatch at %0t: rd_data = %02h, expected %02h (frame %0d, byte %0d)",
                         $time, rd_data, expected, frames_checked, byte_idx);
                errors++;
                frame_errors++;
            end
            byte_idx++;
            if (byte_idx == exp_len) begin
                if (frame_errors == 0) begin
                    $display("frame %0d: pass, %0d bytes", frames_checked, exp_len);
                end else begin
                    $display("frame %0d: fail, %0d of %0d bytes wrong",
                             frames_checked, frame_errors, exp_len);
                end
                frames_checked++;
                byte_idx     = 0;
                frame_errors = 0;
            end
        end
        rd_en_q <= rd_en;
    end

endmodule

// File: tb/frame_tb.sv
`timescale 1ns/1ps

module frame_tb;

    localparam int n_frames    = 6;
    localparam int rec_len     = 34;
    localparam int clk_period  = 10;
    localparam int watchdog_ns = n_frames * 200 * clk_period;

    // readback ranges in sweep order: link, type, temp, data
    localparam logic [11:0] pkt_base [4] = '{12'hfcc, 12'hfc0, 12'hfc8, 12'h000};
    localparam int          pkt_len  [4] = '{6, 6, 4, 10};

    logic        clk;
    logic        rst;
    logic        start;
    logic [31:0] data_reg;
    logic [31:0] data_stat;
    logic [11:0] rd_addr;
    logic        rd_en;
    logic        busy;
    logic        frame_done;
    logic [7:0]  rd_data;
    logic [7:0]  golden [n_frames*rec_len];
    int          errors;
    int          frames_checked;
    int          bytes_checked;
    int          drive_errors;

    frame_top frame_top_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .data_reg   (data_reg),
        .data_stat  (data_stat),
        .rd_addr    (rd_addr),
        .busy       (busy),
        .frame_done (frame_done),
        .rd_data    (rd_data)
    );

    frame_checker #(
        .n_frames (n_frames),
        .rec_len  (rec_len)
    ) frame_checker_i (
        .clk            (clk),
        .rd_en          (rd_en),
        .rd_data        (rd_data),
        .errors         (errors),
        .frames_checked (frames_checked),
        .bytes_checked  (bytes_checked)
    );

    initial clk = 1'b0;
    always #(clk_period/2) clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic wait_frame_done();
        while (!frame_done) begin
            next_cycle();
        end
    endtask

    // the first eight bytes of a record are data_reg and data_stat
    task automatic load_stimulus(input int f);
        int b;
        b = f * rec_len;
        data_reg  = {golden[b], golden[b+1], golden[b+2], golden[b+3]};
        data_stat = {golden[b+4], golden[b+5], golden[b+6], golden[b+7]};
    endtask

    task automatic sweep_packets();
        for (int p = 0; p < 4; p++) begin
            for (int j = 0; j < pkt_len[p]; j++) begin
                rd_addr = pkt_base[p] + 12'(j);
                rd_en   = 1'b1;
                next_cycle();
            end
        end
        rd_en = 1'b0;
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        data_reg     = '0;
        data_stat    = '0;
        rd_addr      = '0;
        rd_en        = 1'b0;
        drive_errors = 0;
        $readmemh("tb/frame_golden.txt", golden);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();
        next_cycle();
        if (busy || frame_done) begin
            $display("busy or frame_done is active after reset");
            drive_errors++;
        end
        for (int f = 0; f < n_frames; f++) begin
            load_stimulus(f);
            pulse_start();
            // odd frames get a second start while the frame runs, it must be ignored
            if (f % 2 == 1) begin
                if (!busy) begin
                    $display("busy did not rise after start in frame %0d", f);
                    drive_errors++;
                end
                pulse_start();
            end
            wait_frame_done();
            sweep_packets();
        end
        wait (frames_checked == n_frames);
        next_cycle();
        $display("frames checked %0d, bytes checked %0d, errors %0d",
                 frames_checked, bytes_checked, errors + drive_errors);
        if (errors + drive_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the frames did not complete within %0d ns", watchdog_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: tb/frame_golden.txt
// per frame: data_reg and data_stat bytes (msb first), then the expected
// readback of the link, type, temp and data packets, header to checksum
// frame 0
12 34 56 78 9a bc de f0
80 12 34 56 78 94
90 9a bc de f0 b4
a0 01 90 31
d0 07 06 05 04 03 02 01 00 ec
// frame 1
de ad be ef 00 00 00 00
81 de ad be ef b9
91 00 00 00 00 91
a1 01 91 33
d1 0f 0e 0d 0c 0b 0a 09 08 2d
// frame 2
ff ff ff ff 01 02 03 04
82 ff ff ff ff 7e
92 01 02 03 04 9c
a2 01 92 35
d2 17 16 15 14 13 12 11 10 6e
// frame 3
a5 a5 a5 a5 5a 5a 5a 5a
83 a5 a5 a5 a5 17
93 5a 5a 5a 5a fb
a3 01 93 37
d3 1f 1e 1d 1c 1b 1a 19 18 af
// frame 4
00 00 00 01 80 00 00 00
84 00 00 00 01 85
94 80 00 00 00 14
a4 01 94 39
d4 27 26 25 24 23 22 21 20 f0
// frame 5
ca fe f0 0d 13 57 9b df
85 ca fe f0 0d 4a
95 13 57 9b df 79
a5 01 95 3b
d5 2f 2e 2d 2c 2b 2a 29 28 31

// File: compile.f
rtl/frame_pkg.sv
rtl/sample_source.sv
rtl/frame_sequencer.sv
rtl/packet_builder.sv
rtl/frame_buffer.sv
rtl/frame_top.sv
tb/frame_checker.sv
tb/frame_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run, then scan the log for the failure line
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module frame_tb \
    -f compile.f -o frame_sim \
    && ./obj_dir/frame_sim 2>&1 | tee sim.log \
    || { echo "compile or simulation failed"; exit 1; }

grep -q "Finished with errors" sim.log && exit 1 || exit 0
